// ==== verilog/sxt_consts.svh ====
// Sizes, field widths and latencies of the sample-extraction read side
`ifndef SXT_CONSTS_SVH
`define SXT_CONSTS_SVH

// ----------------------------------------
// Polynomial geometry
// ----------------------------------------
`define SXT_N            64
`define SXT_N_W          6
// One mask polynomial plus the body
`define SXT_GLWE_K       1
`define SXT_GLWE_K_P1    (`SXT_GLWE_K + 1)
`define SXT_POLY_ID_W    1
// 16 coefficients per RAM word
`define SXT_RD_COEF_W    4
`define SXT_STG_ITER_NB  4
`define SXT_STG_ITER_W   2

// ----------------------------------------
// GLWE RAM banks
// ----------------------------------------
`define SXT_GRAM_NB      4
`define SXT_GRAM_ID_W    2
// Low bits pick the bank, high bits the slot
`define SXT_PID_W        4
`define SXT_SLOT_DEPTH   (`SXT_STG_ITER_NB * `SXT_GLWE_K_P1)
`define SXT_RAM_ADD_W    5

// ----------------------------------------
// Command fields
// ----------------------------------------
`define SXT_REGID_W      6
// LUT count is 1, 2 or 4
`define SXT_LOG_LUT_W    2
`define SXT_LUT_ID_W     2

// ----------------------------------------
// Latencies and buffering
// ----------------------------------------
`define SXT_DATA_LATENCY 3
// RAM latency, read data pipe and two formatter stages
`define SXT_SR_DEPTH     (`SXT_DATA_LATENCY + 3)
`define SXT_JOIN_DEPTH   8
`define SXT_JOIN_CNT_W   4

`endif

// ==== verilog/sxt_pkg.sv ====
// Command, read-item and formatter context struct types
`include "sxt_consts.svh"

package sxt_pkg;

  // ----------------------------------------
  // Input command
  // ----------------------------------------
  typedef struct packed {
    // LWE body, the rotation amount
    logic [`SXT_N_W-1:0]       body;
    // Ciphertext slot id
    logic [`SXT_PID_W-1:0]     pid;
    // Base destination register
    logic [`SXT_REGID_W-1:0]   dst_rid;
    // Log2 of the LUT count
    logic [`SXT_LOG_LUT_W-1:0] log_lut_nb;
  } sxt_cmd_t;

  // ----------------------------------------
  // One GLWE RAM read request
  // ----------------------------------------
  typedef struct packed {
    logic [`SXT_PID_W-1:0]      pid;
    // Base register ORed with the LUT id
    logic [`SXT_REGID_W-1:0]    dst_rid;
    // First word of the slot in the bank
    logic [`SXT_RAM_ADD_W-1:0]  add_ofs;
    logic [`SXT_POLY_ID_W-1:0]  poly_id;
    logic [`SXT_STG_ITER_W-1:0] stg_iter;
    // Bank to read
    logic [`SXT_GRAM_ID_W-1:0]  grid;
    // Body plus LUT offset, mod N
    logic [`SXT_N_W-1:0]        rot_factor;
    logic                       is_body;
    // Set on the last LUT of a command
    logic                       is_last;
  } sxt_rd_item_t;

  // ----------------------------------------
  // Read context for the formatter
  // ----------------------------------------
  typedef struct packed {
    logic [`SXT_PID_W-1:0]                   pid;
    logic [`SXT_REGID_W-1:0]                 dst_rid;
    // Natural-order index of the first coefficient
    logic [`SXT_N_W-1:0]                     id_0;
    // Word index inside the polynomial
    logic [`SXT_N_W-`SXT_RD_COEF_W-1:0]     add_local;
    logic [`SXT_N_W-1:0]                     rot_factor;
    logic                                    is_body;
    logic                                    is_last;
  } sxt_ctx_t;

endpackage

// ==== verilog/sxt_pipe_stage.sv ====
// One-entry valid/ready register stage with a type-parameter payload
`timescale 1ns/100ps

module sxt_pipe_stage
  import sxt_pkg::*;
#(
  parameter type payload_t = sxt_cmd_t
)
(
  input  logic     clk,
  input  logic     s_rst_n,

  // Upstream side
  input  logic     in_vld,
  output logic     in_rdy,
  input  payload_t in_data,

  // Downstream side
  output logic     out_vld,
  input  logic     out_rdy,
  output payload_t out_data
);

  // ----------------------------------------
  // Control
  // ----------------------------------------
  logic do_load;

  // Room when empty, or when the entry leaves this cycle
  assign in_rdy  = ~out_vld | out_rdy;
  assign do_load = in_vld & in_rdy;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_vld <= 1'b0;
    end
    else if (in_rdy) begin
      // Refill or drain
      out_vld <= in_vld;
    end
  end

  // ----------------------------------------
  // Payload
  // ----------------------------------------
  // Only written on a transfer, no reset
  always_ff @(posedge clk) begin
    if (do_load) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== verilog/sxt_cmd_decode.sv ====
// Command input stage, LUT/poly/iteration counters, read item build and join credit count
`timescale 1ns/100ps

`include "sxt_consts.svh"

module sxt_cmd_decode
  import sxt_pkg::*;
(
  input  logic         clk,
  input  logic         s_rst_n,

  // Command input
  input  logic         in_cmd_vld,
  output logic         in_cmd_rdy,
  input  sxt_cmd_t     in_cmd,

  // Join buffer read strobe
  input  logic         buf_cnt_do_dec,

  // Read items to execute
  output logic         item_vld,
  input  logic         item_rdy,
  output sxt_rd_item_t item
);

  // ----------------------------------------
  // Input stage
  // ----------------------------------------
  logic     s0_vld;
  logic     s0_rdy;
  sxt_cmd_t s0_cmd;

  sxt_pipe_stage #(
    .payload_t (sxt_cmd_t)
  ) cmd_stage (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_vld   (in_cmd_vld),
    .in_rdy   (in_cmd_rdy),
    .in_data  (in_cmd),
    .out_vld  (s0_vld),
    .out_rdy  (s0_rdy),
    .out_data (s0_cmd)
  );

  // Last LUT id from the LUT count
  logic [`SXT_LUT_ID_W-1:0] last_lut_id;
  logic [`SXT_LUT_ID_W-1:0] in_lut_mask;

  assign last_lut_id = ~({`SXT_LUT_ID_W{1'b1}} << s0_cmd.log_lut_nb);
  // Same mask on the incoming command, for the alignment check
  assign in_lut_mask = ~({`SXT_LUT_ID_W{1'b1}} << in_cmd.log_lut_nb);

  // ----------------------------------------
  // Iteration counters
  // ----------------------------------------
  logic [`SXT_STG_ITER_W-1:0] stg_iter;
  logic [`SXT_POLY_ID_W-1:0]  poly_id;
  logic [`SXT_LUT_ID_W-1:0]   lut_id;
  logic                       is_body;
  logic                       last_stg_iter;
  logic                       last_lut;
  logic                       free_loc;
  logic                       do_read;

  // Body is the last polynomial, read in a single iteration
  assign is_body       = poly_id == `SXT_POLY_ID_W'(`SXT_GLWE_K);
  assign last_stg_iter = is_body | (stg_iter == `SXT_STG_ITER_W'(`SXT_STG_ITER_NB - 1));
  assign last_lut      = lut_id == last_lut_id;

  // One item per cycle while there is room in the join buffer
  assign item_vld = s0_vld & free_loc;
  assign do_read  = item_vld & item_rdy;
  // Release the command with its last item
  assign s0_rdy   = item_rdy & free_loc & last_stg_iter & is_body & last_lut;

  // Iteration fastest, then poly, then LUT
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      stg_iter <= '0;
      poly_id  <= '0;
      lut_id   <= '0;
    end
    else if (do_read) begin
      stg_iter <= last_stg_iter ? '0 : stg_iter + 1'b1;
      if (last_stg_iter) begin
        poly_id <= is_body ? '0 : poly_id + 1'b1;
        if (is_body) begin
          lut_id <= last_lut ? '0 : lut_id + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Read item fields
  // ----------------------------------------
  logic [`SXT_N_W-1:0] lut_ofs;

  // LUTs are spread evenly around the negacyclic ring
  assign lut_ofs = `SXT_N_W'(lut_id) << (`SXT_N_W - s0_cmd.log_lut_nb);

  assign item.pid        = s0_cmd.pid;
  // Base id is aligned, so OR gives consecutive registers
  assign item.dst_rid    = s0_cmd.dst_rid | `SXT_REGID_W'(lut_id);
  assign item.add_ofs    = `SXT_RAM_ADD_W'(s0_cmd.pid[`SXT_PID_W-1:`SXT_GRAM_ID_W]
                           * `SXT_SLOT_DEPTH);
  assign item.poly_id    = poly_id;
  assign item.stg_iter   = stg_iter;
  assign item.grid       = s0_cmd.pid[`SXT_GRAM_ID_W-1:0];
  // Wraps mod N by width
  assign item.rot_factor = s0_cmd.body + lut_ofs;
  assign item.is_body    = is_body;
  assign item.is_last    = last_lut;

  // ----------------------------------------
  // Join buffer credit
  // ----------------------------------------
  logic                       dec_r;
  logic [`SXT_JOIN_CNT_W-1:0] buf_cnt;

  // Credit return, registered once
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      dec_r   <= 1'b0;
      buf_cnt <= '0;
    end
    else begin
      dec_r   <= buf_cnt_do_dec;
      buf_cnt <= buf_cnt + `SXT_JOIN_CNT_W'(do_read) - `SXT_JOIN_CNT_W'(dec_r);
    end
  end

  assign free_loc = buf_cnt < `SXT_JOIN_CNT_W'(`SXT_JOIN_DEPTH);

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Base register must leave room for every LUT output
  a_rid_aligned : assert property (@(posedge clk) disable iff (!s_rst_n)
    (in_cmd_vld && in_cmd_rdy) |->
      ((in_cmd.dst_rid[`SXT_LUT_ID_W-1:0] & in_lut_mask) == '0))
    else $error("dst_rid not aligned to the LUT count");

  // No credit returned for a word that was never read
  a_cnt_no_underflow : assert property (@(posedge clk) disable iff (!s_rst_n)
    dec_r |-> (buf_cnt != '0 || do_read))
    else $error("join credit counter underflow");

endmodule

// ==== verilog/sxt_addr_gen.sv ====
// Execute stage with bit-reversed GLWE RAM address and bank grant gating
`timescale 1ns/100ps

`include "sxt_consts.svh"

module sxt_addr_gen
  import sxt_pkg::*;
(
  input  logic                      clk,
  input  logic                      s_rst_n,

  // Read items from decode
  input  logic                      item_vld,
  output logic                      item_rdy,
  input  sxt_rd_item_t              item,

  // Bank grants, one bit per bank
  input  logic [`SXT_GRAM_NB-1:0]   gram_avail_1h,

  // GLWE RAM read
  output logic                      rd_en,
  output logic [`SXT_RAM_ADD_W-1:0] rd_add,
  output logic [`SXT_GRAM_ID_W-1:0] rd_grid,

  // Context of the read
  output sxt_ctx_t                  ctx
);

  // Bit reverse over N_W
  function automatic logic [`SXT_N_W-1:0] rev_n(input logic [`SXT_N_W-1:0] v);
    logic [`SXT_N_W-1:0] r;
    for (int i = 0; i < `SXT_N_W; i++) begin
      r[i] = v[`SXT_N_W-1-i];
    end
    return r;
  endfunction

  // ----------------------------------------
  // Item stage and grant
  // ----------------------------------------
  logic                    s1_vld;
  logic                    s1_rdy;
  sxt_rd_item_t            s1_item;
  logic [`SXT_GRAM_NB-1:0] gnt_r;

  sxt_pipe_stage #(
    .payload_t (sxt_rd_item_t)
  ) item_stage (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_vld   (item_vld),
    .in_rdy   (item_rdy),
    .in_data  (item),
    .out_vld  (s1_vld),
    .out_rdy  (s1_rdy),
    .out_data (s1_item)
  );

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      gnt_r <= '0;
    end
    else begin
      gnt_r <= gram_avail_1h;
    end
  end

  // Leaves on the grant cycle of its own bank
  assign s1_rdy = gnt_r[s1_item.grid];
  assign rd_en  = s1_vld & s1_rdy;

  // ----------------------------------------
  // Address
  // ----------------------------------------
  logic [`SXT_N_W-1:0]                 rd_dec;
  logic [`SXT_N_W-1:0]                 id_0;
  logic [`SXT_N_W-1:0]                 idx_0;
  logic [`SXT_N_W-`SXT_RD_COEF_W-1:0] add_local;

  // Iteration offset in natural order
  assign rd_dec    = rev_n(`SXT_N_W'(s1_item.stg_iter) << `SXT_RD_COEF_W);
  assign id_0      = s1_item.rot_factor - rd_dec;
  // RAM holds coefficients bit-reversed
  assign idx_0     = rev_n(id_0);
  assign add_local = idx_0[`SXT_N_W-1:`SXT_RD_COEF_W];

  assign rd_add  = `SXT_RAM_ADD_W'({s1_item.poly_id, add_local}) + s1_item.add_ofs;
  assign rd_grid = s1_item.grid;

  // Context for the result stage
  assign ctx.pid        = s1_item.pid;
  assign ctx.dst_rid    = s1_item.dst_rid;
  assign ctx.id_0       = id_0;
  assign ctx.add_local  = add_local;
  assign ctx.rot_factor = s1_item.rot_factor;
  assign ctx.is_body    = s1_item.is_body;
  assign ctx.is_last    = s1_item.is_last;

  // Item without its registered bank grant stays put until granted
  a_wait_for_grant : assert property (@(posedge clk) disable iff (!s_rst_n)
    (s1_vld && !gnt_r[s1_item.grid]) |=> (s1_vld && $stable(s1_item)))
    else $error("read item left the execute stage without a bank grant");

endmodule

// ==== verilog/sxt_result_delay.sv ====
// Fixed-latency delay line that hands read context over with the RAM data
`timescale 1ns/100ps

`include "sxt_consts.svh"

module sxt_result_delay
  import sxt_pkg::*;
(
  input  logic     clk,
  input  logic     s_rst_n,

  // From the read stage
  input  logic     in_avail,
  input  sxt_ctx_t in_ctx,

  // To the formatter
  output logic     x0_avail,
  output sxt_ctx_t x0_ctx
);

  // ----------------------------------------
  // Shift register
  // ----------------------------------------
  logic [`SXT_SR_DEPTH-1:0] avail_sr;
  sxt_ctx_t                 ctx_sr [`SXT_SR_DEPTH];

  // Valid bits are control state
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_sr <= '0;
    end
    else begin
      avail_sr <= {avail_sr[`SXT_SR_DEPTH-2:0], in_avail};
    end
  end

  // Context just follows along
  always_ff @(posedge clk) begin
    ctx_sr[0] <= in_ctx;
    for (int i = 1; i < `SXT_SR_DEPTH; i++) begin
      ctx_sr[i] <= ctx_sr[i-1];
    end
  end

  // Read data is on the RAM output here
  assign x0_avail = avail_sr[`SXT_SR_DEPTH-1];
  assign x0_ctx   = ctx_sr[`SXT_SR_DEPTH-1];

endmodule

// ==== verilog/sxt_read.sv ====
// Top of the sample-extraction read side: decode, execute and result stages
`timescale 1ns/100ps

`include "sxt_consts.svh"

module sxt_read
  import sxt_pkg::*;
(
  input  logic                      clk,
  input  logic                      s_rst_n,

  // Command input
  input  logic                      in_cmd_vld,
  output logic                      in_cmd_rdy,
  input  sxt_cmd_t                  in_cmd,

  // Bank grants and join buffer credit return
  input  logic [`SXT_GRAM_NB-1:0]   gram_avail_1h,
  input  logic                      buf_cnt_do_dec,

  // GLWE RAM read
  output logic                      rd_en,
  output logic [`SXT_RAM_ADD_W-1:0] rd_add,
  output logic [`SXT_GRAM_ID_W-1:0] rd_grid,

  // To the formatter
  output logic                      x0_avail,
  output sxt_ctx_t                  x0_ctx
);

  // ----------------------------------------
  // Decode to execute
  // ----------------------------------------
  logic         item_vld;
  logic         item_rdy;
  sxt_rd_item_t item;
  sxt_ctx_t     rd_ctx;

  sxt_cmd_decode u_decode (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .in_cmd_vld     (in_cmd_vld),
    .in_cmd_rdy     (in_cmd_rdy),
    .in_cmd         (in_cmd),
    .buf_cnt_do_dec (buf_cnt_do_dec),
    .item_vld       (item_vld),
    .item_rdy       (item_rdy),
    .item           (item)
  );

  // Address and grant
  sxt_addr_gen u_addr_gen (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .item_vld      (item_vld),
    .item_rdy      (item_rdy),
    .item          (item),
    .gram_avail_1h (gram_avail_1h),
    .rd_en         (rd_en),
    .rd_add        (rd_add),
    .rd_grid       (rd_grid),
    .ctx           (rd_ctx)
  );

  // ----------------------------------------
  // Result
  // ----------------------------------------
  sxt_result_delay u_result (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .in_avail (rd_en),
    .in_ctx   (rd_ctx),
    .x0_avail (x0_avail),
    .x0_ctx   (x0_ctx)
  );

endmodule

// ==== verification/sxt_clk_gen.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/100ps

module sxt_clk_gen (
  output logic clk,
  output logic s_rst_n
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset low for the first 3 rising edges
  initial begin
    s_rst_n = 1'b0;
    repeat (3) @(posedge clk);
    s_rst_n <= 1'b1;
  end

endmodule

// ==== verification/sxt_read_tb.sv ====
// Testbench for the read side: stimulus, reference model, read and context checks, timeout
`timescale 1ns/100ps

`include "sxt_consts.svh"

module sxt_read_tb
  import sxt_pkg::*;
;

  // ----------------------------------------
  // Test constants and modes
  // ----------------------------------------
  localparam int NUM_RAND       = 12;
  // Random commands, one grant block command, one credit command
  localparam int NUM_CMDS       = NUM_RAND + 2;
  localparam int TIMEOUT_CYC    = 40 * NUM_CMDS + 200;
  localparam int WORDS_PER_POLY = `SXT_N >> `SXT_RD_COEF_W;
  localparam int GNT_ALL    = 0;
  localparam int GNT_RANDOM = 1;
  localparam int GNT_BLOCK  = 2;
  localparam int CR_OFF     = 0;
  localparam int CR_RANDOM  = 1;
  localparam int CR_DRAIN   = 2;
  localparam int CR_ONE     = 3;

  // Expected read and its context
  typedef struct packed {
    logic [`SXT_RAM_ADD_W-1:0] add;
    logic [`SXT_GRAM_ID_W-1:0] grid;
    sxt_ctx_t                  ctx;
  } exp_rd_t;

  logic                      clk;
  logic                      s_rst_n;
  logic                      in_cmd_vld;
  logic                      in_cmd_rdy;
  sxt_cmd_t                  in_cmd;
  logic [`SXT_GRAM_NB-1:0]   gram_avail_1h;
  logic                      buf_cnt_do_dec;
  logic                      rd_en;
  logic [`SXT_RAM_ADD_W-1:0] rd_add;
  logic [`SXT_GRAM_ID_W-1:0] rd_grid;
  logic                      x0_avail;
  sxt_ctx_t                  x0_ctx;

  integer                  seed = 6360;
  int                      cyc = 0;
  int                      chk_cnt = 0;
  int                      err_cnt = 0;
  int                      rd_cnt = 0;
  int                      credit_cnt = 0;
  int                      grant_mode;
  int                      credit_mode;
  int                      blocked_bank = 0;
  string                   test_name = "reset";
  logic [`SXT_GRAM_NB-1:0] last_gnt = '0;
  exp_rd_t                 exp_q [$];
  sxt_ctx_t                pend_q [$];
  int                      due_q [$];

  sxt_clk_gen clk_gen (
    .clk     (clk),
    .s_rst_n (s_rst_n)
  );

  sxt_read UUT (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .in_cmd_vld     (in_cmd_vld),
    .in_cmd_rdy     (in_cmd_rdy),
    .in_cmd         (in_cmd),
    .gram_avail_1h  (gram_avail_1h),
    .buf_cnt_do_dec (buf_cnt_do_dec),
    .rd_en          (rd_en),
    .rd_add         (rd_add),
    .rd_grid        (rd_grid),
    .x0_avail       (x0_avail),
    .x0_ctx         (x0_ctx)
  );

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic int reverse_bits(input int v);
    int r;
    r = 0;
    for (int i = 0; i < `SXT_N_W; i++) begin
      r = (r << 1) | ((v >> i) & 1);
    end
    return r;
  endfunction

  // All reads of one command, iteration fastest, then poly, then LUT
  function automatic void add_expected_reads(input sxt_cmd_t cmd);
    int      lut_nb;
    int      rot;
    int      iters;
    int      dec;
    int      id0;
    int      word;
    exp_rd_t e;
    lut_nb = 1 << cmd.log_lut_nb;
    for (int lut = 0; lut < lut_nb; lut++) begin
      // LUTs evenly spaced on the ring
      rot = (cmd.body + lut * (`SXT_N / lut_nb)) % `SXT_N;
      for (int poly = 0; poly <= `SXT_GLWE_K; poly++) begin
        iters = (poly == `SXT_GLWE_K) ? 1 : `SXT_STG_ITER_NB;
        for (int it = 0; it < iters; it++) begin
          dec  = reverse_bits(it << `SXT_RD_COEF_W);
          id0  = (rot + `SXT_N - dec) % `SXT_N;
          word = reverse_bits(id0) >> `SXT_RD_COEF_W;
          e.add  = (poly * WORDS_PER_POLY + word
                   + (cmd.pid >> `SXT_GRAM_ID_W) * `SXT_SLOT_DEPTH) % (1 << `SXT_RAM_ADD_W);
          e.grid = cmd.pid % `SXT_GRAM_NB;
          e.ctx.pid        = cmd.pid;
          e.ctx.dst_rid    = cmd.dst_rid | lut;
          e.ctx.id_0       = id0;
          e.ctx.add_local  = word;
          e.ctx.rot_factor = rot;
          e.ctx.is_body    = (poly == `SXT_GLWE_K);
          e.ctx.is_last    = (lut == lut_nb - 1);
          exp_q.push_back(e);
        end
      end
    end
  endfunction

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic sxt_cmd_t make_random_cmd();
    sxt_cmd_t c;
    c.body       = $random(seed);
    c.pid        = $random(seed);
    c.log_lut_nb = $unsigned($random(seed)) % 3;
    c.dst_rid    = $random(seed);
    // Base register aligned to the LUT count
    c.dst_rid    = c.dst_rid & ~((`SXT_REGID_W'(1) << c.log_lut_nb) - 1'b1);
    return c;
  endfunction

  task automatic check_field(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    chk_cnt++;
    if (exp_v !== act_v) begin
      err_cnt++;
      $display("ERR %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  // Called on a rising edge, returns on the transfer edge
  task automatic send_cmd(input sxt_cmd_t c);
    in_cmd     <= c;
    in_cmd_vld <= 1'b1;
    do @(negedge clk); while (!in_cmd_rdy);
    @(posedge clk);
  endtask

  task automatic wait_drain();
    do @(posedge clk); while (exp_q.size() != 0 || due_q.size() != 0);
  endtask

  task automatic print_counts();
    $display("%0d checks, %0d reads, %0d errors", chk_cnt, rd_cnt, err_cnt);
  endtask

  // ----------------------------------------
  // Grant and credit return stimulus
  // ----------------------------------------
  always @(posedge clk) begin
    case (grant_mode)
      GNT_ALL:    gram_avail_1h <= '1;
      GNT_RANDOM: gram_avail_1h <= $random(seed) | $random(seed);
      default:    gram_avail_1h <= ($random(seed) | $random(seed)) & ~(1 << blocked_bank);
    endcase
  end

  // Never returns more credits than reads seen
  always @(posedge clk) begin
    if (credit_mode != CR_OFF && rd_cnt > credit_cnt &&
        (credit_mode != CR_RANDOM || ($random(seed) & 3) != 0)) begin
      buf_cnt_do_dec <= 1'b1;
      credit_cnt++;
      if (credit_mode == CR_ONE) begin
        credit_mode = CR_OFF;
      end
    end
    else begin
      buf_cnt_do_dec <= 1'b0;
    end
  end

  // ----------------------------------------
  // Compare process, sampled mid-cycle
  // ----------------------------------------
  always @(negedge clk) begin : compare
    exp_rd_t e;
    sxt_ctx_t c;
    if (s_rst_n) begin
      if (rd_en) begin
        rd_cnt++;
        // DUT gates on the grant of the previous cycle
        if (!last_gnt[rd_grid]) begin
          report_error($sformatf("read on bank %0d without a grant", rd_grid));
        end
        if (exp_q.size() == 0) begin
          report_error("read issued with no read expected");
        end
        else begin
          e = exp_q.pop_front();
          check_field("rd_add", e.add, rd_add);
          check_field("rd_grid", e.grid, rd_grid);
          pend_q.push_back(e.ctx);
          due_q.push_back(cyc + `SXT_SR_DEPTH);
        end
      end
      if (x0_avail) begin
        if (due_q.size() == 0) begin
          report_error("x0_avail with no read pending");
        end
        else begin
          check_field("x0 cycle", due_q.pop_front(), cyc);
          c = pend_q.pop_front();
          check_field("pid", c.pid, x0_ctx.pid);
          check_field("dst_rid", c.dst_rid, x0_ctx.dst_rid);
          check_field("id_0", c.id_0, x0_ctx.id_0);
          check_field("add_local", c.add_local, x0_ctx.add_local);
          check_field("rot_factor", c.rot_factor, x0_ctx.rot_factor);
          check_field("is_body", c.is_body, x0_ctx.is_body);
          check_field("is_last", c.is_last, x0_ctx.is_last);
        end
      end
      else if (due_q.size() != 0 && due_q[0] == cyc) begin
        report_error("x0_avail missing for an issued read");
        void'(due_q.pop_front());
        void'(pend_q.pop_front());
      end
      // Only the last item of the held command may still be unread
      if (in_cmd_vld && in_cmd_rdy) begin
        if (exp_q.size() > 1) begin
          report_error($sformatf("command accepted with %0d earlier reads pending",
                                 exp_q.size()));
        end
        add_expected_reads(in_cmd);
      end
    end
    last_gnt = gram_avail_1h;
  end

  // ----------------------------------------
  // Timeout
  // ----------------------------------------
  always @(posedge clk) begin
    cyc++;
    if (cyc > TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, %0d reads never issued", cyc, exp_q.size());
      print_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main
    sxt_cmd_t c;
    int       rd_base;
    in_cmd_vld     = 1'b0;
    in_cmd         = '0;
    gram_avail_1h  = '0;
    buf_cnt_do_dec = 1'b0;
    grant_mode     = GNT_RANDOM;
    credit_mode    = CR_RANDOM;
    wait (s_rst_n);
    @(posedge clk);

    // Random commands back to back
    test_name = "random_cmds";
    for (int i = 0; i < NUM_RAND; i++) begin
      send_cmd(make_random_cmd());
    end
    in_cmd_vld <= 1'b0;
    wait_drain();

    // Bank of the command held without grant
    c = make_random_cmd();
    @(negedge clk);
    test_name    = "grant_block";
    blocked_bank = c.pid % `SXT_GRAM_NB;
    grant_mode   = GNT_BLOCK;
    @(posedge clk);
    rd_base = rd_cnt;
    send_cmd(c);
    in_cmd_vld <= 1'b0;
    repeat (30) @(posedge clk);
    check_field("reads while grant low", 0, rd_cnt - rd_base);
    @(negedge clk);
    grant_mode = GNT_RANDOM;
    wait_drain();
    check_field("reads after grant", 5 << c.log_lut_nb, rd_cnt - rd_base);

    // Empty the join count, then stop credits
    @(negedge clk);
    test_name   = "credit_limit";
    grant_mode  = GNT_ALL;
    credit_mode = CR_DRAIN;
    while (credit_cnt != rd_cnt) @(negedge clk);
    credit_mode = CR_OFF;
    repeat (4) @(negedge clk);
    @(posedge clk);
    rd_base = rd_cnt;
    c = make_random_cmd();
    c.log_lut_nb = 2;
    c.dst_rid    = c.dst_rid & ~`SXT_REGID_W'(3);
    send_cmd(c);
    in_cmd_vld <= 1'b0;
    repeat (30) @(posedge clk);
    $display("credit_limit: %0d reads with no credit returned", rd_cnt - rd_base);
    check_field("reads without credit", `SXT_JOIN_DEPTH, rd_cnt - rd_base);
    @(negedge clk);
    credit_mode = CR_ONE;
    repeat (12) @(posedge clk);
    $display("credit_limit: %0d reads after one credit", rd_cnt - rd_base);
    check_field("reads after one credit", `SXT_JOIN_DEPTH + 1, rd_cnt - rd_base);
    @(negedge clk);
    credit_mode = CR_RANDOM;
    wait_drain();

    print_counts();
    if (err_cnt == 0) begin
      $display("TEST OK");
    end
    else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sxt_read.f ====
+incdir+verilog
verilog/sxt_pkg.sv
verilog/sxt_pipe_stage.sv
verilog/sxt_cmd_decode.sv
verilog/sxt_addr_gen.sv
verilog/sxt_result_delay.sv
verilog/sxt_read.sv
verification/sxt_clk_gen.sv
verification/sxt_read_tb.sv
